/* sim.f */
+incdir+.
lsu_pkg.sv
mem_word_pkg.sv
store_aligner.sv
load_aligner.sv
byte_ram.sv
lsu_ctrl.sv
lsu_top.sv
tb_lsu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the load/store unit testbench with Verilator, runs it and
# checks the log for the pass line.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
	-f sim.f --top-module tb_lsu -o tb_lsu

./obj_dir/tb_lsu | tee sim.log

if grep -qx "All checks passed" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* tb_lsu_model.svh */
/*
 * Reference model for the load/store unit testbench.
 * Holds a copy of the data memory and turns each accepted request into the
 * expected response. Included inside tb_lsu after the lsu_pkg import.
 */

`ifndef TB_LSU_MODEL_SVH
`define TB_LSU_MODEL_SVH

logic [31:0] model_mem [TB_DEPTH]; // mirror of the dut ram

// rv32 alignment rules
function automatic logic model_legal(input lsu_width_t w, input logic [1:0] lsb);
	case (w)
		LSU_BYTE: return 1'b1;
		LSU_HALF: return lsb[0] == 1'b0; // even byte address
		LSU_WORD: return lsb == 2'b00;
		default:  return 1'b0;           // no width code 11
	endcase
endfunction

// applies a store to the model and returns {err, rdata}
function automatic logic [32:0] model_access(input lsu_req_t r);
	logic [$clog2(TB_DEPTH)-1:0] idx;
	logic [1:0]                  lsb;
	int                          nbytes;
	logic [31:0]                 word;
	logic [31:0]                 val;
	idx = r.addr[2 +: $clog2(TB_DEPTH)]; // upper bits wrap
	lsb = r.addr[1:0];
	if (!model_legal(r.width, lsb)) begin
		return {1'b1, 32'h0}; // refused, memory untouched
	end
	nbytes = (r.width == LSU_BYTE) ? 1 : (r.width == LSU_HALF) ? 2 : 4;
	word   = model_mem[idx];
	if (r.is_store) begin
		for (int k = 0; k < nbytes; k++) begin
			word[8*(lsb+k) +: 8] = r.wdata[8*k +: 8]; // little endian lanes
		end
		model_mem[idx] = word;
		return 33'h0; // stores return zero data
	end
	val = 32'h0;
	for (int k = 0; k < nbytes; k++) begin
		val[8*k +: 8] = word[8*(lsb+k) +: 8];
	end
	if (!r.is_unsigned && nbytes < 4 && val[8*nbytes-1]) begin
		for (int k = nbytes; k < 4; k++) begin
			val[8*k +: 8] = 8'hff; // sign fill
		end
	end
	return {1'b0, val};
endfunction

`endif

/* tb_lsu.sv */
/*
 * Testbench for the load/store unit with a 16-word RAM.
 * Drives directed and LFSR-random requests on falling edges, mirrors every
 * accepted request in a model and checks responses in order.
 */

`timescale 1ns/10ps
`default_nettype none

module tb_lsu;
	import lsu_pkg::*;

	localparam int TB_DEPTH    = 16;  // small ram so addresses collide
	localparam int N_INIT      = 16;  // one word store per ram word
	localparam int N_WORD_RW   = 32;  // store/load pairs
	localparam int N_LANE_ST   = 48;  // lane store plus word load
	localparam int N_LANE_LD   = 26;  // two patterns, twelve loads each
	localparam int N_MISALIGN  = 40;  // refused access plus word load
	localparam int N_RANDOM    = 200;
	localparam int N_STREAM    = 32;
	localparam int TOTAL_REQS  = N_INIT + N_WORD_RW + N_LANE_ST + N_LANE_LD + N_MISALIGN
		+ N_RANDOM + N_STREAM;
	localparam int CYCLE_LIMIT = 8 * TOTAL_REQS;

	logic      clk;
	logic      reset;
	logic      req_valid;
	logic      req_ready;
	lsu_req_t  req;
	logic      resp_valid;
	logic      resp_ready;
	lsu_resp_t resp;

	logic [31:0] lfsr_q = 32'hc16d_751e; // stimulus seed
	logic [32:0] exp_q [$];              // expected {err, rdata}, oldest first
	logic        backpressure = 1'b0;    // random resp ready and request gaps
	int          cycle_cnt = 0;          // rising edges so far
	string       test_name;
	int          test_reqs, test_errs;
	int          n_tests = 0;
	int          n_checks = 0;
	int          n_errors = 0;
	logic        stream_on = 1'b0; // timing checks of the back-to-back test
	int          stream_acc, stream_rsp;
	int          first_acc_edge, last_acc_edge, last_rsp_edge;

	`include "tb_lsu_model.svh"

	lsu_top #(
		.DEPTH_WORDS(TB_DEPTH)
	) dut_i (
		.clk_i        (clk),
		.reset_i      (reset),
		.req_valid_i  (req_valid),
		.req_ready_o  (req_ready),
		.req_i        (req),
		.resp_valid_o (resp_valid),
		.resp_ready_i (resp_ready),
		.resp_o       (resp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: run stopped after %0d cycles with %0d responses outstanding",
				cycle_cnt, exp_q.size());
			$display("Checks failed");
			$finish;
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic next_bit();
		logic fb;
		fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
		lfsr_q = {lfsr_q[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = 32'h0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], next_bit()}; // one step per bit
		end
		return v;
	endfunction

	// random upper bits exercise the address wrap
	function automatic logic [31:0] wrap_addr(input logic [3:0] idx, input logic [1:0] lsb);
		logic [31:0] hi;
		hi = rand_bits(26);
		return {hi[25:0], idx, lsb};
	endfunction

	function automatic lsu_req_t make_req(input logic st, input logic uns, input lsu_width_t w,
		input logic [31:0] a, input logic [31:0] d);
		lsu_req_t r;
		r.is_store    = st;
		r.is_unsigned = uns;
		r.width       = w;
		r.addr        = a;
		r.wdata       = d;
		return r;
	endfunction

	task automatic check_val(input string name, input logic [32:0] exp, input logic [32:0] act);
		n_checks++;
		if (exp !== act) begin
			n_errors++;
			test_errs++;
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic take_response(input int at_edge);
		if (exp_q.size() == 0) begin
			n_errors++;
			test_errs++;
			$display("%s: response arrived with no request outstanding", test_name);
		end else begin
			check_val(test_name, exp_q.pop_front(), resp);
		end
		if (stream_on) begin
			if (stream_rsp == 0) begin
				check_val({test_name, " latency"}, 33'd2, 33'(at_edge - first_acc_edge));
			end else begin
				check_val({test_name, " resp spacing"}, 33'd1, 33'(at_edge - last_rsp_edge));
			end
			last_rsp_edge = at_edge;
			stream_rsp++;
		end
	endtask

	task automatic accept_request(input lsu_req_t r, input int at_edge);
		exp_q.push_back(model_access(r)); // stores land in the model now
		test_reqs++;
		if (stream_on) begin
			if (stream_acc == 0) begin
				first_acc_edge = at_edge;
			end else begin
				check_val({test_name, " accept spacing"}, 33'd1, 33'(at_edge - last_acc_edge));
			end
			last_acc_edge = at_edge;
			stream_acc++;
		end
	endtask

	// drive at the falling edge, decide both handshakes of the next rising edge
	task automatic run_cycle(input logic valid, input lsu_req_t r, output logic taken);
		logic rdy;
		int   at_edge;
		@(negedge clk);
		rdy        = backpressure ? next_bit() : 1'b1;
		req_valid  = valid;
		req        = r;
		resp_ready = rdy;
		#1;
		at_edge = cycle_cnt + 1;
		taken   = valid & req_ready;
		if (resp_valid && rdy) begin
			take_response(at_edge);
		end
		if (taken) begin
			accept_request(r, at_edge);
		end
	endtask

	task automatic send_req(input lsu_req_t r);
		logic taken;
		int   gap;
		gap = 0;
		while (backpressure && gap < 3 && !next_bit()) begin
			run_cycle(1'b0, r, taken); // idle before the request
			gap++;
		end
		taken = 1'b0;
		while (!taken) begin
			run_cycle(1'b1, r, taken); // payload held until accepted
		end
	endtask

	task automatic drain();
		logic t;
		while (exp_q.size() != 0) begin
			run_cycle(1'b0, req, t);
		end
		repeat (2) run_cycle(1'b0, req, t); // a duplicate would show here
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_reqs = 0;
		test_errs = 0;
	endtask

	task automatic end_test();
		drain();
		n_tests++;
		$display("test %s: %0d requests, %0d errors", test_name, test_reqs, test_errs);
	endtask

	task automatic run_directed();
		logic [3:0]  idx;
		logic [1:0]  lsb;
		logic [31:0] pat;
		lsu_width_t  w;
		begin_test("mem_init");
		for (int i = 0; i < N_INIT; i++) begin
			send_req(make_req(1'b1, 1'b0, LSU_WORD, wrap_addr(4'(i), 2'b00), rand_bits(32)));
		end
		end_test();
		begin_test("word_store_load");
		for (int i = 0; i < N_WORD_RW / 2; i++) begin
			idx = 4'(rand_bits(4));
			send_req(make_req(1'b1, 1'b0, LSU_WORD, wrap_addr(idx, 2'b00), rand_bits(32)));
			send_req(make_req(1'b0, 1'b0, LSU_WORD, wrap_addr(idx, 2'b00), 32'h0));
		end
		end_test();
		begin_test("lane_store");
		for (int i = 0; i < N_LANE_ST / 2; i++) begin
			idx = 4'(rand_bits(4));
			w   = next_bit() ? LSU_HALF : LSU_BYTE;
			lsb = 2'(rand_bits(2));
			if (w == LSU_HALF) begin
				lsb[0] = 1'b0; // keep half-words aligned
			end
			send_req(make_req(1'b1, 1'b0, w, wrap_addr(idx, lsb), rand_bits(32)));
			send_req(make_req(1'b0, 1'b0, LSU_WORD, wrap_addr(idx, 2'b00), 32'h0));
		end
		end_test();
		begin_test("lane_load_extend");
		for (int p = 0; p < 2; p++) begin
			idx = 4'(rand_bits(4));
			pat = (p == 0) ? 32'h80ff_7f01 : 32'h017f_ff80; // both sign states per lane
			send_req(make_req(1'b1, 1'b0, LSU_WORD, wrap_addr(idx, 2'b00), pat));
			for (int u = 0; u < 2; u++) begin
				for (int lane = 0; lane < 4; lane++) begin
					send_req(make_req(1'b0, 1'(u), LSU_BYTE, wrap_addr(idx, 2'(lane)), 32'h0));
				end
				for (int h = 0; h < 2; h++) begin
					send_req(make_req(1'b0, 1'(u), LSU_HALF, wrap_addr(idx, 2'(2 * h)), 32'h0));
				end
			end
		end
		end_test();
	endtask

	task automatic run_misaligned();
		logic [3:0] idx;
		logic [1:0] lsb;
		logic [1:0] kind;
		lsu_width_t w;
		begin_test("misaligned");
		for (int i = 0; i < N_MISALIGN / 2; i++) begin
			idx  = 4'(rand_bits(4));
			kind = 2'(rand_bits(2));
			lsb  = 2'(rand_bits(2));
			if (kind == 2'd0) begin
				w      = LSU_HALF;
				lsb[0] = 1'b1; // odd address
			end else if (kind == 2'd1) begin
				w = LSU_WORD;
				if (lsb == 2'b00) begin
					lsb = 2'b10;
				end
			end else begin
				w = LSU_INVALID; // any offset
			end
			send_req(make_req(next_bit(), next_bit(), w, wrap_addr(idx, lsb), rand_bits(32)));
			send_req(make_req(1'b0, 1'b0, LSU_WORD, wrap_addr(idx, 2'b00), 32'h0));
		end
		end_test();
	endtask

	// every field random, width code 11 included
	function automatic lsu_req_t rand_req();
		logic        st;
		logic        uns;
		logic [1:0]  w;
		logic [3:0]  idx;
		logic [1:0]  lsb;
		st  = next_bit();
		w   = 2'(rand_bits(2));
		uns = next_bit();
		idx = 4'(rand_bits(4));
		lsb = 2'(rand_bits(2));
		return make_req(st, uns, lsu_width_t'(w), wrap_addr(idx, lsb), rand_bits(32));
	endfunction

	task automatic run_random();
		begin_test("random_backpressure");
		backpressure = 1'b1;
		for (int i = 0; i < N_RANDOM; i++) begin
			send_req(rand_req());
		end
		end_test();
		backpressure = 1'b0;
		begin_test("back_to_back");
		stream_on  = 1'b1;
		stream_acc = 0;
		stream_rsp = 0;
		for (int i = 0; i < N_STREAM; i++) begin
			send_req(rand_req());
		end
		end_test();
		stream_on = 1'b0;
	endtask

	initial begin
		reset      = 1'b1;
		req_valid  = 1'b0;
		req        = '0;
		resp_ready = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		#1;
		begin_test("reset_state");
		check_val(test_name, 33'b10, 33'({req_ready, resp_valid})); // ready up, no response
		end_test();
		run_directed();
		run_misaligned();
		run_random();
		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* lsu_top.sv */
/*
 * Load/store unit with its own data RAM.
 * Requests and responses use valid/ready handshakes with a two-edge latency.
 * DEPTH_WORDS sets the RAM size; addresses wrap above it.
 */

`timescale 1ns/10ps
`default_nettype none

module lsu_top #(
	parameter int DEPTH_WORDS = 256 // ram words
) (
	input  logic               clk_i,
	input  logic               reset_i,
	input  logic               req_valid_i,
	output logic               req_ready_o,
	input  lsu_pkg::lsu_req_t  req_i,
	output logic               resp_valid_o,
	input  logic               resp_ready_i,
	output lsu_pkg::lsu_resp_t resp_o
);
	import lsu_pkg::*;
	import mem_word_pkg::*;

	byte_mask_t                     amask;         // ungated store mask
	mem_word_u                      st_wdata;      // lane aligned store data
	byte_mask_t                     ram_mask;      // gated store mask
	logic                           ram_re;
	logic [$clog2(DEPTH_WORDS)-1:0] ram_index;
	mem_word_u                      ram_rdata;     // registered read word
	logic [1:0]                     pend_lsb;
	lsu_width_t                     pend_width;
	logic                           pend_unsigned;
	logic [31:0]                    aligned_rdata; // extended load value

	lsu_ctrl #(
		.DEPTH_WORDS(DEPTH_WORDS)
	) ctrl_i (
		.clk_i           (clk_i),
		.reset_i         (reset_i),
		.req_valid_i     (req_valid_i),
		.req_ready_o     (req_ready_o),
		.req_i           (req_i),
		.amask_i         (amask),
		.ram_mask_o      (ram_mask),
		.ram_re_o        (ram_re),
		.ram_index_o     (ram_index),
		.pend_lsb_o      (pend_lsb),
		.pend_width_o    (pend_width),
		.pend_unsigned_o (pend_unsigned),
		.aligned_rdata_i (aligned_rdata),
		.resp_valid_o    (resp_valid_o),
		.resp_ready_i    (resp_ready_i),
		.resp_o          (resp_o)
	);

	store_aligner st_align_i (
		.wdata_i    (req_i.wdata),
		.addr_lsb_i (req_i.addr[1:0]),
		.width_i    (req_i.width),
		.wdata_o    (st_wdata),
		.mask_o     (amask)
	);

	byte_ram #(
		.DEPTH_WORDS(DEPTH_WORDS)
	) ram_i (
		.clk_i     (clk_i),
		.we_mask_i (ram_mask),
		.re_i      (ram_re),
		.index_i   (ram_index),
		.wdata_i   (st_wdata),
		.rdata_o   (ram_rdata)
	);

	load_aligner ld_align_i (
		.rword_i       (ram_rdata),
		.addr_lsb_i    (pend_lsb),
		.width_i       (pend_width),
		.is_unsigned_i (pend_unsigned),
		.rdata_o       (aligned_rdata)
	);

endmodule

`default_nettype wire

/* lsu_ctrl.sv */
/*
 * Load/store control with a request stage, a pending stage and a response slot.
 * Accepted requests hit the ram at the accept edge and the result lands in the
 * response register one edge later. The pending stage stalls on back-pressure.
 */

`timescale 1ns/10ps
`default_nettype none

module lsu_ctrl #(
	parameter int DEPTH_WORDS = 256 // ram words
) (
	input  logic                           clk_i,
	input  logic                           reset_i,
	// request side
	input  logic                           req_valid_i,
	output logic                           req_ready_o,
	input  lsu_pkg::lsu_req_t              req_i,
	// ram side
	input  mem_word_pkg::byte_mask_t       amask_i,     // from store aligner
	output mem_word_pkg::byte_mask_t       ram_mask_o,  // gated write mask
	output logic                           ram_re_o,
	output logic [$clog2(DEPTH_WORDS)-1:0] ram_index_o,
	// load aligner side
	output logic [1:0]                     pend_lsb_o,
	output lsu_pkg::lsu_width_t            pend_width_o,
	output logic                           pend_unsigned_o,
	input  logic [31:0]                    aligned_rdata_i,
	// response side
	output logic                           resp_valid_o,
	input  logic                           resp_ready_i,
	output lsu_pkg::lsu_resp_t             resp_o
);
	import lsu_pkg::*;

	localparam int IDX_W = $clog2(DEPTH_WORDS); // word index bits

	// what stage 2 must remember about an accepted request
	typedef struct packed {
		logic       is_store;
		logic       is_unsigned;
		lsu_width_t width;
		logic [1:0] lsb;
		logic       err; // refused at accept
	} pend_t;

	pend_t     pend_q;       // pending op payload
	logic      pend_valid_q; // pending op present
	lsu_resp_t resp_q;       // response slot
	logic      resp_valid_q; // response slot full

	logic      aligned;  // request passes the alignment check
	logic      req_fire; // request handshake this edge
	logic      pend_adv; // pending op moves to response slot
	logic      ram_go;   // accepted and legal

	// alignment from width and byte offset
	always_comb begin
		case (req_i.width)
			LSU_BYTE: aligned = 1'b1;                      // any offset
			LSU_HALF: aligned = ~req_i.addr[0];            // even address
			LSU_WORD: aligned = (req_i.addr[1:0] == 2'b00); // word boundary
			default:  aligned = 1'b0;                      // code 11
		endcase
	end

	assign pend_adv    = pend_valid_q & (~resp_valid_q | resp_ready_i); // slot free or draining
	assign req_ready_o = ~pend_valid_q | pend_adv;                      // stall only when stuck
	assign req_fire    = req_valid_i & req_ready_o;
	assign ram_go      = req_fire & aligned;

	assign ram_mask_o  = amask_i & {4{ram_go & req_i.is_store}}; // stores only
	assign ram_re_o    = ram_go & ~req_i.is_store;               // loads only
	assign ram_index_o = req_i.addr[IDX_W+1:2];                  // upper bits wrap

	// pending stage
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pend_valid_q <= 1'b0;
		end else if (req_fire) begin
			pend_valid_q <= 1'b1;
		end else if (pend_adv) begin
			pend_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (req_fire) begin
			pend_q.is_store    <= req_i.is_store;
			pend_q.is_unsigned <= req_i.is_unsigned;
			pend_q.width       <= req_i.width;
			pend_q.lsb         <= req_i.addr[1:0];
			pend_q.err         <= ~aligned;
		end
	end

	// response slot
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			resp_valid_q <= 1'b0;
		end else if (pend_adv) begin
			resp_valid_q <= 1'b1;
		end else if (resp_ready_i) begin
			resp_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (pend_adv) begin
			resp_q.err   <= pend_q.err;
			resp_q.rdata <= (pend_q.err | pend_q.is_store) ? '0 : aligned_rdata_i; // loads only
		end
	end

	assign pend_lsb_o      = pend_q.lsb;
	assign pend_width_o    = pend_q.width;
	assign pend_unsigned_o = pend_q.is_unsigned;

	assign resp_valid_o = resp_valid_q;
	assign resp_o       = resp_q;

endmodule

`default_nettype wire

/* byte_ram.sv */
/*
 * Single-port data RAM of 32-bit words with one write enable per byte lane.
 * Read data is registered on edges where the read enable is high and holds
 * otherwise. Writes and reads never share a cycle.
 */

`timescale 1ns/10ps
`default_nettype none

module byte_ram #(
	parameter int DEPTH_WORDS = 256 // number of words
) (
	input  logic                           clk_i,
	input  mem_word_pkg::byte_mask_t       we_mask_i, // per lane write enable
	input  logic                           re_i,      // read enable
	input  logic [$clog2(DEPTH_WORDS)-1:0] index_i,   // word index
	input  mem_word_pkg::mem_word_u        wdata_i,   // lane aligned write data
	output mem_word_pkg::mem_word_u        rdata_o    // registered read word
);
	import mem_word_pkg::*;

	mem_word_u mem [DEPTH_WORDS]; // storage array

	// lane writes
	always_ff @(posedge clk_i) begin
		for (int lane = 0; lane < 4; lane++) begin
			if (we_mask_i[lane]) begin
				mem[index_i].b[lane] <= wdata_i.b[lane];
			end
		end
	end

	// read register, held while re_i is low
	always_ff @(posedge clk_i) begin
		if (re_i) begin
			rdata_o <= mem[index_i];
		end
	end

endmodule

`default_nettype wire

/* load_aligner.sv */
/*
 * Load data extraction.
 * Selects the addressed byte or half-word from a registered ram word and
 * extends it to register width. Driven from the controller's pending stage.
 */

`timescale 1ns/10ps
`default_nettype none

module load_aligner (
	input  mem_word_pkg::mem_word_u rword_i,       // word read from ram
	input  logic [1:0]              addr_lsb_i,    // byte offset in word
	input  lsu_pkg::lsu_width_t     width_i,       // access width
	input  logic                    is_unsigned_i, // 1 zero extend, 0 sign extend
	output logic [31:0]             rdata_o        // register value
);
	import lsu_pkg::*;
	import mem_word_pkg::*;

	logic [7:0]  sel_byte; // addressed byte lane
	logic [15:0] sel_half; // addressed half-word
	logic        ext_b;    // fill bit for byte
	logic        ext_h;    // fill bit for half

	assign sel_byte = pick_byte(rword_i, addr_lsb_i);
	assign sel_half = pick_half(rword_i, addr_lsb_i[1]); // bit 0 ignored

	assign ext_b = ~is_unsigned_i & sel_byte[7];
	assign ext_h = ~is_unsigned_i & sel_half[15];

	always_comb begin
		case (width_i)
			LSU_BYTE: rdata_o = {{24{ext_b}}, sel_byte};
			LSU_HALF: rdata_o = {{16{ext_h}}, sel_half};
			LSU_WORD: rdata_o = rword_i;        // whole word
			default:  rdata_o = '0;             // refused anyway
		endcase
	end

endmodule

`default_nettype wire

/* store_aligner.sv */
/*
 * Store data realignment.
 * Copies the register byte or half-word onto every lane and raises the mask
 * bit of the addressed lanes only. The controller gates the mask.
 */

`timescale 1ns/10ps
`default_nettype none

module store_aligner (
	input  logic [31:0]              wdata_i,    // register data
	input  logic [1:0]               addr_lsb_i, // byte offset in word
	input  lsu_pkg::lsu_width_t      width_i,    // access width
	output mem_word_pkg::mem_word_u  wdata_o,    // data on ram lanes
	output mem_word_pkg::byte_mask_t mask_o      // lanes to write
);
	import lsu_pkg::*;
	import mem_word_pkg::*;

	always_comb begin
		case (width_i)
			LSU_BYTE: begin
				wdata_o.b = {4{wdata_i[7:0]}};           // byte on all lanes
				mask_o    = byte_lane_mask(addr_lsb_i);  // only addressed lane
			end
			LSU_HALF: begin
				wdata_o.h = {2{wdata_i[15:0]}};             // half on both halves
				mask_o    = half_lane_mask(addr_lsb_i[1]); // low or high pair
			end
			LSU_WORD: begin
				wdata_o = wdata_i; // straight through
				mask_o  = MASK_ALL;
			end
			default: begin
				wdata_o = wdata_i; // keep lanes defined
				mask_o  = '0;      // nothing written for code 11
			end
		endcase
	end

endmodule

`default_nettype wire

/* mem_word_pkg.sv */
/*
 * Memory word views and byte-lane helpers.
 * Shared by the aligners and the data RAM.
 */

`default_nettype none

package mem_word_pkg;

	typedef logic [3:0] byte_mask_t; // bit n enables byte lane n

	// one ram word, seen as bytes or as half-words
	typedef union packed {
		logic [3:0][7:0]  b; // b[0] is the lsb lane
		logic [1:0][15:0] h; // h[0] is the low half
	} mem_word_u;

	localparam byte_mask_t MASK_ALL = 4'b1111; // full word write

	function automatic byte_mask_t byte_lane_mask(input logic [1:0] lane);
		return byte_mask_t'(4'b0001 << lane); // one hot on the lane
	endfunction

	function automatic byte_mask_t half_lane_mask(input logic upper);
		return upper ? 4'b1100 : 4'b0011;
	endfunction

	function automatic logic [7:0] pick_byte(input mem_word_u w, input logic [1:0] lane);
		return w.b[lane];
	endfunction

	function automatic logic [15:0] pick_half(input mem_word_u w, input logic upper);
		return w.h[upper];
	endfunction

endpackage

`default_nettype wire

/* lsu_pkg.sv */
/*
 * Load/store request and response formats for the data-memory side of the core.
 * The width codes are the low two bits of the RV32 funct3 field.
 * Imported by the controller, the store aligner and the load aligner.
 */

`default_nettype none

package lsu_pkg;

	// access width, funct3[1:0]
	typedef enum logic [1:0] {
		LSU_BYTE    = 2'b00, // lb/lbu/sb
		LSU_HALF    = 2'b01, // lh/lhu/sh
		LSU_WORD    = 2'b10, // lw/sw
		LSU_INVALID = 2'b11  // no such access on rv32
	} lsu_width_t;

	// one request from the core
	typedef struct packed {
		logic        is_store;    // 1 store, 0 load
		logic        is_unsigned; // zero extend on load
		lsu_width_t  width;       // access width
		logic [31:0] addr;        // byte address
		logic [31:0] wdata;       // register data for stores
	} lsu_req_t;

	// one response back to the core
	typedef struct packed {
		logic        err;   // refused access
		logic [31:0] rdata; // load result, zero otherwise
	} lsu_resp_t;

endpackage

`default_nettype wire
